//--- Makefile
# Verilator flow for the axi2per bridge

TB_TOP = axi2per_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module axi2per \
	  hw/axi2per_axi_pkg.sv hw/axi2per_per_pkg.sv hw/axi2per_trans_if.sv \
	  hw/axi2per_req_channel.sv hw/axi2per_res_channel.sv hw/axi2per.sv

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TB_TOP) \
	  -f axi2per.f --Mdir obj_dir -o $(TB_TOP)
	./obj_dir/$(TB_TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- axi2per.f
hw/axi2per_axi_pkg.sv
hw/axi2per_per_pkg.sv
hw/axi2per_trans_if.sv
hw/axi2per_req_channel.sv
hw/axi2per_res_channel.sv
hw/axi2per.sv
verif/axi2per_checker.sv
verif/axi2per_tb.sv

//--- hw/axi2per.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI64 to 32-bit peripheral bridge, one beat and one transaction at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module axi2per (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  axi2per_per_pkg::cluster_id_t  cluster_id_i,  // Selects the address window

  // AXI read address
  input  logic                          ar_valid_i,
  input  axi2per_axi_pkg::axi_addr_t    ar_addr_i,
  input  axi2per_axi_pkg::axi_id_t      ar_id_i,
  output logic                          ar_ready_o,

  // AXI write address and data
  input  logic                          aw_valid_i,
  input  axi2per_axi_pkg::axi_addr_t    aw_addr_i,
  input  axi2per_axi_pkg::axi_id_t      aw_id_i,
  output logic                          aw_ready_o,
  input  logic                          w_valid_i,
  input  axi2per_axi_pkg::axi_data_t    w_data_i,
  input  axi2per_axi_pkg::axi_strb_t    w_strb_i,
  output logic                          w_ready_o,

  // AXI read response
  output logic                          r_valid_o,
  output axi2per_axi_pkg::axi_data_t    r_data_o,
  output axi2per_axi_pkg::axi_id_t      r_id_o,
  output axi2per_axi_pkg::axi_resp_t    r_resp_o,
  output logic                          r_last_o,
  input  logic                          r_ready_i,

  // AXI write response
  output logic                          b_valid_o,
  output axi2per_axi_pkg::axi_id_t      b_id_o,
  output axi2per_axi_pkg::axi_resp_t    b_resp_o,
  input  logic                          b_ready_i,

  // Peripheral port
  output logic                          per_req_o,
  output axi2per_per_pkg::per_addr_t    per_add_o,
  output logic                          per_wen_o,     // High for a read
  output axi2per_per_pkg::per_data_t    per_wdata_o,
  output axi2per_per_pkg::per_be_t      per_be_o,
  input  logic                          per_gnt_i,
  input  logic                          per_r_valid_i,
  input  logic                          per_r_opc_i,
  input  axi2per_per_pkg::per_data_t    per_r_rdata_i,

  output logic                          busy_o
);

  axi2per_trans_if trans ();  // Handover between the two channels

  axi2per_req_channel req_channel_i (
    .clk_i, .rst_ni, .cluster_id_i,
    .ar_valid_i, .ar_addr_i, .ar_id_i, .ar_ready_o,
    .aw_valid_i, .aw_addr_i, .aw_id_i, .aw_ready_o,
    .w_valid_i, .w_data_i, .w_strb_i, .w_ready_o,
    .per_req_o, .per_add_o, .per_wen_o, .per_wdata_o, .per_be_o, .per_gnt_i,
    .trans      (trans),
    .busy_o
  );

  axi2per_res_channel res_channel_i (
    .clk_i, .rst_ni,
    .per_r_valid_i, .per_r_opc_i, .per_r_rdata_i,
    .r_valid_o, .r_data_o, .r_id_o, .r_resp_o, .r_last_o, .r_ready_i,
    .b_valid_o, .b_id_o, .b_resp_o, .b_ready_i,
    .trans      (trans)
  );

endmodule

//--- hw/axi2per_axi_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI slave side, single beat only: no len, size, burst or side fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package axi2per_axi_pkg;

  localparam int unsigned AXI_ADDR_WIDTH = 32;
  localparam int unsigned AXI_DATA_WIDTH = 64;  // Two 32-bit lanes
  localparam int unsigned AXI_STRB_WIDTH = 8;   // One strobe per data byte
  localparam int unsigned AXI_ID_WIDTH   = 3;

  typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
  typedef logic [AXI_STRB_WIDTH-1:0] axi_strb_t;
  typedef logic [AXI_ID_WIDTH-1:0]   axi_id_t;
  typedef logic [1:0]                axi_resp_t;

  // Response codes, EXOKAY and DECERR never produced
  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

endpackage

//--- hw/axi2per_per_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral port is 32-bit wide, window stride fixed per cluster
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package axi2per_per_pkg;

  typedef logic [31:0] per_addr_t;
  typedef logic [31:0] per_data_t;
  typedef logic [3:0]  per_be_t;
  typedef logic [5:0]  cluster_id_t;  // Up to 64 clusters

  // Spacing of the cluster peripheral windows
  localparam per_addr_t CLUSTER_ADDR_STRIDE = 32'h0040_0000;

  // Address bit picking the upper 32-bit lane of a 64-bit beat
  localparam int unsigned LANE_SEL_BIT = 2;

endpackage

//--- hw/axi2per_req_channel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read wins over write, one request outstanding until trans.done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module axi2per_req_channel (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  axi2per_per_pkg::cluster_id_t  cluster_id_i,

  // AXI read address
  input  logic                          ar_valid_i,
  input  axi2per_axi_pkg::axi_addr_t    ar_addr_i,
  input  axi2per_axi_pkg::axi_id_t      ar_id_i,
  output logic                          ar_ready_o,

  // AXI write address and data
  input  logic                          aw_valid_i,
  input  axi2per_axi_pkg::axi_addr_t    aw_addr_i,
  input  axi2per_axi_pkg::axi_id_t      aw_id_i,
  output logic                          aw_ready_o,
  input  logic                          w_valid_i,
  input  axi2per_axi_pkg::axi_data_t    w_data_i,
  input  axi2per_axi_pkg::axi_strb_t    w_strb_i,
  output logic                          w_ready_o,

  // Peripheral request
  output logic                          per_req_o,
  output axi2per_per_pkg::per_addr_t    per_add_o,
  output logic                          per_wen_o,
  output axi2per_per_pkg::per_data_t    per_wdata_o,
  output axi2per_per_pkg::per_be_t      per_be_o,
  input  logic                          per_gnt_i,

  axi2per_trans_if.req_mp               trans,

  output logic                          busy_o
);

  typedef enum logic {
    IDLE,
    PENDING
  } state_e;

  state_e                     state_d, state_q;
  axi2per_axi_pkg::axi_addr_t sel_addr;     // Address of the winning channel
  axi2per_per_pkg::per_addr_t win_offset;   // Base of this cluster's window
  logic                       rd_req;
  logic                       wr_req;
  logic                       upper_lane;

  assign rd_req     = ar_valid_i;                 // Read has priority
  assign wr_req     = aw_valid_i && w_valid_i;    // Write needs both AW and W
  assign sel_addr   = rd_req ? ar_addr_i : aw_addr_i;
  assign upper_lane = aw_addr_i[axi2per_per_pkg::LANE_SEL_BIT];

  // Window offset, product truncated to the 32-bit address
  assign win_offset = axi2per_per_pkg::CLUSTER_ADDR_STRIDE *
                      axi2per_per_pkg::per_addr_t'(cluster_id_i);

  // Address is translated whether or not a request is up
  assign per_add_o  = axi2per_per_pkg::per_addr_t'(sel_addr) - win_offset;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d     = state_q;
    ar_ready_o  = 1'b0;
    aw_ready_o  = 1'b0;
    w_ready_o   = 1'b0;
    per_req_o   = 1'b0;
    per_wen_o   = 1'b0;
    per_wdata_o = '0;
    per_be_o    = '0;
    trans.req   = 1'b0;
    trans.wen   = 1'b0;
    trans.id    = '0;
    trans.addr  = '0;
    busy_o      = 1'b0;

    case (state_q)
      IDLE: begin
        if (rd_req) begin
          per_req_o = 1'b1;
          per_wen_o = 1'b1;  // Enable is high for a read
          if (per_gnt_i) begin
            ar_ready_o = 1'b1;  // Accept cycle
            trans.req  = 1'b1;
            trans.wen  = 1'b1;
            trans.id   = ar_id_i;
            trans.addr = ar_addr_i;
            state_d    = PENDING;
          end
        end else if (wr_req) begin
          per_req_o = 1'b1;
          // Pick the 32-bit lane and its strobes
          if (upper_lane) begin
            per_wdata_o = w_data_i[63:32];
            per_be_o    = w_strb_i[7:4];
          end else begin
            per_wdata_o = w_data_i[31:0];
            per_be_o    = w_strb_i[3:0];
          end
          if (per_gnt_i) begin
            aw_ready_o = 1'b1;
            w_ready_o  = 1'b1;  // AW and W leave together
            trans.req  = 1'b1;
            trans.id   = aw_id_i;
            trans.addr = aw_addr_i;
            state_d    = PENDING;
          end
        end
      end

      PENDING: begin
        busy_o = 1'b1;  // Readies stay low until the response is taken
        if (trans.done) begin
          state_d = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

endmodule

//--- hw/axi2per_res_channel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expects per_r_valid_i only after a granted request, beat held until ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module axi2per_res_channel (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Peripheral response
  input  logic                         per_r_valid_i,
  input  logic                         per_r_opc_i,   // High on error
  input  axi2per_per_pkg::per_data_t   per_r_rdata_i,

  // AXI read response
  output logic                         r_valid_o,
  output axi2per_axi_pkg::axi_data_t   r_data_o,
  output axi2per_axi_pkg::axi_id_t     r_id_o,
  output axi2per_axi_pkg::axi_resp_t   r_resp_o,
  output logic                         r_last_o,
  input  logic                         r_ready_i,

  // AXI write response
  output logic                         b_valid_o,
  output axi2per_axi_pkg::axi_id_t     b_id_o,
  output axi2per_axi_pkg::axi_resp_t   b_resp_o,
  input  logic                         b_ready_i,

  axi2per_trans_if.res_mp              trans
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    RESPOND
  } state_e;

  state_e                     state_d, state_q;

  // Transaction details, taken on trans.req
  logic                       wen_q;
  axi2per_axi_pkg::axi_id_t   id_q;
  logic                       lane_q;       // Only the lane bit of the address matters

  // Response payload, taken on per_r_valid_i
  axi2per_per_pkg::per_data_t rdata_q;
  axi2per_axi_pkg::axi_resp_t resp_q;

  logic                       handshake;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (trans.req) state_d = WAIT;
      WAIT:    if (per_r_valid_i) state_d = RESPOND;
      RESPOND: if (handshake) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && trans.req) begin
      wen_q  <= trans.wen;
      id_q   <= trans.id;
      lane_q <= trans.addr[axi2per_per_pkg::LANE_SEL_BIT];
    end
    if (state_q == WAIT && per_r_valid_i) begin
      rdata_q <= per_r_rdata_i;
      resp_q  <= per_r_opc_i ? axi2per_axi_pkg::RESP_SLVERR : axi2per_axi_pkg::RESP_OKAY;
    end
  end

  assign r_valid_o = (state_q == RESPOND) && wen_q;   // wen high means read
  assign b_valid_o = (state_q == RESPOND) && !wen_q;

  // Read word goes in its lane, other lane zero
  assign r_data_o  = lane_q ? {rdata_q, 32'h0} : {32'h0, rdata_q};
  assign r_id_o    = id_q;
  assign r_resp_o  = resp_q;
  assign r_last_o  = 1'b1;  // Single-beat reads only
  assign b_id_o    = id_q;
  assign b_resp_o  = resp_q;

  assign handshake  = (r_valid_o && r_ready_i) || (b_valid_o && b_ready_i);
  assign trans.done = handshake;  // Frees the request channel

endmodule

//--- hw/axi2per_trans_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One transaction at a time, req and done are single-cycle pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

interface axi2per_trans_if;

  logic                      req;   // Pulses on the peripheral grant
  logic                      wen;   // High for a read
  axi2per_axi_pkg::axi_id_t   id;    // AXI ID to echo back
  axi2per_axi_pkg::axi_addr_t addr;  // Untranslated AXI address
  logic                      done;  // Pulses on the R or B handshake

  // Request channel side
  modport req_mp (
    output req, wen, id, addr,
    input  done
  );

  // Response channel side
  modport res_mp (
    input  req, wen, id, addr,
    output done
  );

endinterface

//--- verif/axi2per_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Samples on falling edges against expected values from the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module axi2per_checker (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        per_req_i, per_gnt_i, per_wen_i, busy_i,
  input  logic [31:0] per_add_i, per_wdata_i,
  input  logic [3:0]  per_be_i,
  input  logic        ar_ready_i, aw_ready_i, w_ready_i,
  input  logic        r_valid_i, r_ready_i, r_last_i, b_valid_i, b_ready_i,
  input  logic [63:0] r_data_i,
  input  logic [2:0]  r_id_i, b_id_i,
  input  logic [1:0]  r_resp_i, b_resp_i,
  input  logic [31:0] exp_add_i, exp_wdata_i,
  input  logic        exp_wen_i,
  input  logic [3:0]  exp_be_i,
  input  logic [63:0] exp_data_i,
  input  logic [2:0]  exp_id_i,
  input  logic [1:0]  exp_resp_i,
  input  logic        test_end_i,
  input  int          test_num_i,
  output int          errors_o,
  output int          tests_o
);

  int          test_errs = 0;
  logic        r_held = 1'b0;  // R beat stalled on the last sample
  logic        b_held = 1'b0;
  logic [63:0] r_data_h;
  logic [2:0]  r_id_h, b_id_h;
  logic [1:0]  r_resp_h, b_resp_h;

  initial begin
    errors_o = 0;
    tests_o  = 0;
  end

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (exp !== got) begin
      $display("Error %s expected %h got %h", name, exp, got);
      errors_o++;
      test_errs++;
    end
  endtask

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      // Everything quiet while in reset
      check_val("per_req_o", 0, per_req_i);
      check_val("ar_ready_o", 0, ar_ready_i);
      check_val("aw_ready_o", 0, aw_ready_i);
      check_val("w_ready_o", 0, w_ready_i);
      check_val("r_valid_o", 0, r_valid_i);
      check_val("b_valid_o", 0, b_valid_i);
      check_val("busy_o", 0, busy_i);
      r_held <= 1'b0;
      b_held <= 1'b0;
    end else begin
      if (per_req_i && per_gnt_i) begin  // Request accepted this cycle
        check_val("per_add_o", exp_add_i, per_add_i);
        check_val("per_wen_o", exp_wen_i, per_wen_i);
        if (!exp_wen_i) begin
          check_val("per_wdata_o", exp_wdata_i, per_wdata_i);
          check_val("per_be_o", exp_be_i, per_be_i);
        end
      end
      // Readies only on the grant cycle of the expected channel
      check_val("ar_ready_o", per_gnt_i && exp_wen_i, ar_ready_i);
      check_val("aw_ready_o", per_gnt_i && !exp_wen_i, aw_ready_i);
      check_val("w_ready_o", per_gnt_i && !exp_wen_i, w_ready_i);
      if (r_valid_i || b_valid_i) begin  // Response owed so nothing new may start
        check_val("busy_o", 1, busy_i);
        check_val("per_req_o", 0, per_req_i);
      end
      if (r_held) begin
        check_val("r_valid_o", 1, r_valid_i);
        check_val("r_data_o", r_data_h, r_data_i);
        check_val("r_id_o", r_id_h, r_id_i);
        check_val("r_resp_o", r_resp_h, r_resp_i);
      end
      if (b_held) begin
        check_val("b_valid_o", 1, b_valid_i);
        check_val("b_id_o", b_id_h, b_id_i);
        check_val("b_resp_o", b_resp_h, b_resp_i);
      end
      if (r_valid_i && r_ready_i) begin
        check_val("r_data_o", exp_data_i, r_data_i);
        check_val("r_id_o", exp_id_i, r_id_i);
        check_val("r_resp_o", exp_resp_i, r_resp_i);
        check_val("r_last_o", 1, r_last_i);
      end
      if (b_valid_i && b_ready_i) begin
        check_val("b_id_o", exp_id_i, b_id_i);
        check_val("b_resp_o", exp_resp_i, b_resp_i);
      end
      r_held   <= r_valid_i && !r_ready_i;
      b_held   <= b_valid_i && !b_ready_i;
      r_data_h <= r_data_i;
      r_id_h   <= r_id_i;
      r_resp_h <= r_resp_i;
      b_id_h   <= b_id_i;
      b_resp_h <= b_resp_i;
    end
    if (test_end_i) begin
      $display("Test %0d finished with %0d errors", test_num_i, test_errs);
      tests_o++;
      test_errs = 0;
    end
  end

endmodule

//--- verif/axi2per_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Error window is peripheral address bits 15:12 equal to E
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module axi2per_tb;

  localparam int TIMEOUT = 200;  // Cycles per wait loop

  logic clk_i = 1'b0;
  logic rst_ni;
  axi2per_per_pkg::cluster_id_t cluster_id_i;
  logic ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o, w_valid_i, w_ready_o;
  axi2per_axi_pkg::axi_addr_t ar_addr_i, aw_addr_i;
  axi2per_axi_pkg::axi_id_t   ar_id_i, aw_id_i, r_id_o, b_id_o;
  axi2per_axi_pkg::axi_data_t w_data_i, r_data_o;
  axi2per_axi_pkg::axi_strb_t w_strb_i;
  axi2per_axi_pkg::axi_resp_t r_resp_o, b_resp_o;
  logic r_valid_o, r_last_o, r_ready_i, b_valid_o, b_ready_i, busy_o;
  logic per_req_o, per_wen_o;
  logic per_gnt_i = 1'b0;
  logic per_r_valid_i = 1'b0;
  logic per_r_opc_i = 1'b0;
  axi2per_per_pkg::per_addr_t per_add_o;
  axi2per_per_pkg::per_data_t per_wdata_o;
  axi2per_per_pkg::per_data_t per_r_rdata_i = '0;
  axi2per_per_pkg::per_be_t   per_be_o;

  // Expected values for the transaction in flight
  logic [31:0] exp_add, exp_wdata;
  logic [63:0] exp_data;
  logic [3:0]  exp_be;
  logic [2:0]  exp_id;
  logic [1:0]  exp_resp;
  logic        exp_wen, test_end;
  int          test_num, errors, tests;
  integer      seed = 32'h87e5;

  logic [31:0] per_mem [256];  // Peripheral model storage
  logic [31:0] ref_mem [256];  // Shadow kept by the reference side
  int          gnt_cnt, rsp_cnt;
  logic        rsp_pend, rsp_err;
  logic [31:0] rsp_data;

  axi2per dut_i (.*);

  axi2per_checker checker_i (
    .clk_i, .rst_ni, .per_req_i(per_req_o), .per_gnt_i, .per_wen_i(per_wen_o),
    .busy_i(busy_o), .per_add_i(per_add_o), .per_wdata_i(per_wdata_o), .per_be_i(per_be_o),
    .ar_ready_i(ar_ready_o), .aw_ready_i(aw_ready_o), .w_ready_i(w_ready_o),
    .r_valid_i(r_valid_o), .r_ready_i, .r_last_i(r_last_o), .b_valid_i(b_valid_o),
    .b_ready_i, .r_data_i(r_data_o), .r_id_i(r_id_o), .b_id_i(b_id_o),
    .r_resp_i(r_resp_o), .b_resp_i(b_resp_o), .exp_add_i(exp_add), .exp_wdata_i(exp_wdata),
    .exp_wen_i(exp_wen), .exp_be_i(exp_be), .exp_data_i(exp_data), .exp_id_i(exp_id),
    .exp_resp_i(exp_resp), .test_end_i(test_end), .test_num_i(test_num),
    .errors_o(errors), .tests_o(tests)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic in_err_window(input logic [31:0] addr);
    return addr[15:12] == 4'hE;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // Expected peripheral request, stored word and AXI response of one access
  function automatic void ref_model(input logic is_read, input logic [31:0] addr,
      input logic [5:0] cid, input logic [63:0] wdata, input logic [7:0] strb,
      input logic [31:0] old_word, output logic [31:0] p_addr, output logic [31:0] p_wdata,
      output logic [3:0] p_be, output logic [31:0] new_word, output logic [63:0] rdata,
      output logic [1:0] resp);
    logic upper;
    upper    = addr[2];  // Upper lane of the beat
    p_addr   = addr - {26'd0, cid} * 32'h0040_0000;
    p_wdata  = upper ? wdata[63:32] : wdata[31:0];
    p_be     = upper ? strb[7:4] : strb[3:0];
    new_word = is_read ? old_word : merge_bytes(old_word, p_wdata, p_be);
    rdata    = upper ? {old_word, 32'h0} : {32'h0, old_word};
    resp     = in_err_window(p_addr) ? 2'd2 : 2'd0;  // SLVERR or OKAY
  endfunction

  // Peripheral model with random grant and response delays
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      per_gnt_i     <= 1'b0;
      per_r_valid_i <= 1'b0;
      per_r_opc_i   <= 1'b0;
      per_r_rdata_i <= '0;
      gnt_cnt       <= 0;
      rsp_pend      <= 1'b0;
    end else begin
      per_gnt_i     <= 1'b0;
      per_r_valid_i <= 1'b0;
      if (per_req_o && per_gnt_i) begin
        if (!per_wen_o) begin
          per_mem[per_add_o[9:2]] <= merge_bytes(per_mem[per_add_o[9:2]], per_wdata_o, per_be_o);
        end
        rsp_data <= per_mem[per_add_o[9:2]];
        rsp_err  <= in_err_window(per_add_o);
        rsp_cnt  <= 1 + $unsigned($random(seed)) % 4;  // 1 to 4 cycles
        rsp_pend <= 1'b1;
      end else if (per_req_o) begin
        if (gnt_cnt == 0) begin
          per_gnt_i <= 1'b1;
          gnt_cnt   <= $unsigned($random(seed)) % 3;
        end else begin
          gnt_cnt <= gnt_cnt - 1;
        end
      end
      if (rsp_pend) begin
        if (rsp_cnt <= 1) begin
          per_r_valid_i <= 1'b1;
          per_r_opc_i   <= rsp_err;
          per_r_rdata_i <= rsp_data;
          rsp_pend      <= 1'b0;
        end else begin
          rsp_cnt <= rsp_cnt - 1;
        end
      end
    end
  end

  task automatic abort_run(input string msg);
    $display("Timeout: %s", msg);
    $display("Test FAILED");
    $finish;
  endtask

  // Runs the reference and loads the expected values on a rising edge
  task automatic expect_for(input logic is_read, input logic [5:0] cid, input logic [31:0] addr,
      input logic [2:0] id, input logic [63:0] wdata, input logic [7:0] strb);
    logic [31:0] pa, pw, nw;
    logic [3:0]  pb;
    logic [63:0] rd;
    logic [1:0]  rs;
    ref_model(is_read, addr, cid, wdata, strb, ref_mem[addr[9:2]], pa, pw, pb, nw, rd, rs);
    ref_mem[addr[9:2]] = nw;
    exp_add   <= pa;
    exp_wdata <= pw;
    exp_be    <= pb;
    exp_data  <= rd;
    exp_resp  <= rs;
    exp_id    <= id;
    exp_wen   <= is_read;
  endtask

  task automatic drive_req(input logic is_read, input logic [31:0] addr, input logic [2:0] id,
      input logic [63:0] wdata, input logic [7:0] strb);
    if (is_read) begin
      ar_valid_i <= 1'b1;
      ar_addr_i  <= addr;
      ar_id_i    <= id;
    end else begin
      aw_valid_i <= 1'b1;
      aw_addr_i  <= addr;
      aw_id_i    <= id;
      w_valid_i  <= 1'b1;
      w_data_i   <= wdata;
      w_strb_i   <= strb;
    end
  endtask

  // Returns after the rising edge that completes the AR or AW/W handshake
  task automatic wait_accept(input logic is_read);
    int   n;
    logic hit;
    n   = 0;
    hit = 1'b0;
    while (!hit && n < TIMEOUT) begin
      @(negedge clk_i);
      hit = is_read ? ar_ready_o : (aw_ready_o && w_ready_o);
      n++;
    end
    if (!hit) abort_run("request was never accepted");
    @(posedge clk_i);
    if (is_read) ar_valid_i <= 1'b0;
    else begin
      aw_valid_i <= 1'b0;
      w_valid_i  <= 1'b0;
    end
  endtask

  // Ready stays low for hold cycles and the task returns on the handshake edge
  task automatic wait_response(input logic is_read, input int hold);
    int   n;
    logic hit;
    n   = 0;
    hit = 1'b0;
    while (!hit && n < TIMEOUT) begin
      @(posedge clk_i);
      r_ready_i <= is_read && n >= hold;
      b_ready_i <= !is_read && n >= hold;
      @(negedge clk_i);
      hit = is_read ? (r_valid_o && r_ready_i) : (b_valid_o && b_ready_i);
      n++;
    end
    if (!hit) abort_run("no R or B handshake");
    @(posedge clk_i);
    r_ready_i <= 1'b0;
    b_ready_i <= 1'b0;
  endtask

  task automatic do_access(input logic is_read, input logic [5:0] cid, input logic [31:0] addr,
      input logic [2:0] id, input logic [63:0] wdata, input logic [7:0] strb, input int hold);
    @(posedge clk_i);
    cluster_id_i <= cid;
    expect_for(is_read, cid, addr, id, wdata, strb);
    drive_req(is_read, addr, id, wdata, strb);
    wait_accept(is_read);
    wait_response(is_read, hold);
  endtask

  task automatic end_test(input int n);
    @(posedge clk_i);
    test_num <= n;
    test_end <= 1'b1;
    @(posedge clk_i);
    test_end <= 1'b0;
  endtask

  function automatic int rnd_hold();
    return $unsigned($random(seed)) % 4;
  endfunction

  initial begin
    logic [31:0] a;
    logic [63:0] d;
    logic [5:0]  cid;
    rst_ni = 1'b0;
    cluster_id_i = '0;
    ar_valid_i = 1'b0;
    ar_addr_i = '0;
    ar_id_i = '0;
    aw_valid_i = 1'b0;
    aw_addr_i = '0;
    aw_id_i = '0;
    w_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    r_ready_i = 1'b0;
    b_ready_i = 1'b0;
    test_end = 1'b0;
    test_num = 0;
    exp_wen = 1'b0;
    for (int i = 0; i < 256; i++) begin
      per_mem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0101);
      ref_mem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0101);
    end
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    end_test(1);  // Reset state checked while rst_ni was low

    for (int i = 0; i < 8; i++) begin  // Both lanes with random strobes
      a = 32'h100 + i * 4;
      d = {$random(seed), $random(seed)};
      do_access(1'b0, 6'd0, a, i[2:0], d, $random(seed), rnd_hold());
      do_access(1'b1, 6'd0, a, i[2:0] + 3'd1, '0, '0, rnd_hold());
    end
    end_test(2);

    for (int i = 0; i < 4; i++) begin  // Clusters 0, 21, 42, 63
      cid = i * 21;
      a   = {26'd0, cid} * 32'h0040_0000 + 32'h200 + i * 4;
      do_access(1'b0, cid, a, 3'd2, {$random(seed), $random(seed)}, 8'hFF, rnd_hold());
      do_access(1'b1, cid, a, 3'd3, '0, '0, rnd_hold());
    end
    end_test(3);

    // Read and write raised together and the read goes first
    // The R beat is stalled while the write waits
    @(posedge clk_i);
    cluster_id_i <= 6'd0;
    expect_for(1'b1, 6'd0, 32'h108, 3'd6, '0, '0);
    drive_req(1'b1, 32'h108, 3'd6, '0, '0);
    drive_req(1'b0, 32'h304, 3'd1, 64'h1122_3344_5566_7788, 8'hF0);
    wait_accept(1'b1);
    wait_response(1'b1, 3);
    expect_for(1'b0, 6'd0, 32'h304, 3'd1, 64'h1122_3344_5566_7788, 8'hF0);
    wait_accept(1'b0);
    wait_response(1'b0, 0);
    end_test(4);

    do_access(1'b0, 6'd1, 32'h0040_E010, 3'd5, 64'hDEAD_BEEF_CAFE_F00D, 8'h0F, 0);
    do_access(1'b1, 6'd1, 32'h0040_E014, 3'd4, '0, '0, 1);
    do_access(1'b1, 6'd1, 32'h0040_0100, 3'd7, '0, '0, 0);
    end_test(5);

    // Long stalls on R and B
    do_access(1'b0, 6'd2, 32'h0080_0400, 3'd2, 64'h0123_4567_89AB_CDEF, 8'h3C, 8);
    do_access(1'b1, 6'd2, 32'h0080_0400, 3'd3, '0, '0, 8);
    end_test(6);

    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) $display("Test OK");
    else $display("Test FAILED");
    $finish;
  end

endmodule
